/* flist.f */
+incdir+common
common/snes_bus_pkg.sv
common/mem_pkg.sv
design/snes_sync.sv
mapper/map_cfg_regs.sv
mapper/lorom_mapper.sv
arbiter/psram_arbiter.sv
design/snes_bus_ctl.sv
design/cart_top.sv
tests/tb_cart_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cartridge controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cart_top \
  -f flist.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0

/* tests/tb_cart_top.sv */
`include "cart_consts.svh"

module tb_cart_top;

  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 20000;   // CLK2 budget per test
  localparam int MCU_LIMIT   = 200;     // One access plus a full console cycle
  localparam int WATCHDOG    = NUM_TESTS * TEST_CYCLES + int'(`SNES_DEAD_TIMEOUT);

  logic        clk2 = 1'b0;
  logic        rst_n;
  logic [23:0] snes_addr;
  logic        snes_rd_n;
  logic        snes_wr_n;
  logic        snes_cpu_clk = 1'b0;
  logic [7:0]  snes_data_in;
  logic [7:0]  snes_data_out;
  logic        snes_databus_oe_n;
  logic        snes_databus_dir;
  logic [22:0] rom_addr;
  logic        rom_we_n;
  logic        rom_bhe_n;
  logic        rom_ble_n;
  logic [15:0] rom_data_in;
  logic [15:0] rom_data_out;
  logic        rom_data_oe;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_wdata;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic        mcu_rdy;
  logic [7:0]  mcu_rdata;
  logic        cfg_we;
  logic [1:0]  cfg_sel;
  logic [23:0] cfg_data;

  logic        cpu_run = 1'b0;
  logic [3:0]  phase_cnt = 4'd0;
  logic [31:0] lfsr_state = 32'h2a5e_a579;
  logic [15:0] psram_mem [65536];    // 64K words, upper address bits alias
  logic [7:0]  ref_mem [131072];     // Byte view of the same space
  logic [23:0] rom_mask;
  logic [23:0] sram_mask;
  string       test_name;
  int          test_errs;
  int          tests_ok = 0;
  int          tests_bad = 0;

  cart_top i_cart_top (.*);

  always #20 clk2 = ~clk2;

  // Console CPU clock, 16 CLK2 cycles per phase
  always @(negedge clk2) begin
    if (cpu_run) begin
      phase_cnt <= phase_cnt + 4'd1;
      if (phase_cnt == 4'd15) snes_cpu_clk <= ~snes_cpu_clk;
    end
  end

  ////////////////////////////////////////////////////////////
  // PSRAM model

  function automatic logic [15:0] fill_word(input logic [15:0] idx);
    fill_word = {idx[7:0], idx[15:8]} ^ 16'h3c5a;
  endfunction

  initial begin
    int i;
    for (i = 0; i < 65536; i++) psram_mem[i] = fill_word(i[15:0]);
  end

  assign rom_data_in = psram_mem[rom_addr[15:0]];

  always @(posedge rom_we_n) begin
    if (rst_n) begin   // Ignore the edge coming out of reset
      if (!rom_ble_n) psram_mem[rom_addr[15:0]][7:0] <= rom_data_out[7:0];
      if (!rom_bhe_n) psram_mem[rom_addr[15:0]][15:8] <= rom_data_out[15:8];
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);   // One step per bit
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      $display("[FAIL] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", test_name, test_errs);
      tests_bad++;
    end
  endtask

  task automatic cfg_write(input logic [1:0] sel, input logic [23:0] data);
    @(negedge clk2);
    cfg_we   = 1'b1;
    cfg_sel  = sel;
    cfg_data = data;
    @(negedge clk2);
    cfg_we = 1'b0;
  endtask

  // One-cycle request pulse, rdy is already low on return
  task automatic mcu_request(input logic write, input logic [23:0] addr, input logic [7:0] data);
    @(negedge clk2);
    mcu_addr  = addr;
    mcu_wdata = data;
    mcu_wrq   = write;
    mcu_rrq   = !write;
    @(negedge clk2);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
  endtask

  task automatic wait_mcu_ready(input int limit);
    int n;
    n = 0;
    while (!mcu_rdy && n < limit) begin
      @(negedge clk2);
      n++;
    end
    if (!mcu_rdy) begin
      $display("Error: %s, mcu_rdy stayed low for %0d cycles", test_name, limit);
      test_errs++;
    end
  endtask

  task automatic mcu_write(input logic [23:0] addr, input logic [7:0] data);
    mcu_request(1'b1, addr, data);
    wait_mcu_ready(MCU_LIMIT);
  endtask

  task automatic mcu_read(input logic [23:0] addr, output logic [7:0] data);
    mcu_request(1'b0, addr, 8'h00);
    wait_mcu_ready(MCU_LIMIT);
    data = mcu_rdata;
  endtask

  // Address and strobes change at the fall, data is taken at the next fall
  task automatic console_access(input logic [23:0] addr, input logic write,
                                input logic [7:0] wdata, output logic [7:0] rdata,
                                output logic oe_n, output logic dir);
    @(negedge snes_cpu_clk);
    snes_addr = addr;
    snes_rd_n = write;
    snes_wr_n = !write;
    if (write) snes_data_in = wdata;
    @(posedge snes_cpu_clk);
    @(negedge snes_cpu_clk);
    rdata = snes_data_out;
    oe_n  = snes_databus_oe_n;
    dir   = snes_databus_dir;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests

  task automatic mcu_roundtrip();
    logic [31:0] r;
    logic [23:0] addr_list [12];
    logic [7:0]  got;
    int          k;
    begin_test("mcu_rw");
    check_val("mcu_rdy after reset", 32'd1, {31'b0, mcu_rdy});
    check_val("rom_we_n after reset", 32'd1, {31'b0, rom_we_n});
    check_val("rom_bhe_n after reset", 32'd1, {31'b0, rom_bhe_n});
    check_val("rom_ble_n after reset", 32'd1, {31'b0, rom_ble_n});
    check_val("rom_data_oe after reset", 32'd0, {31'b0, rom_data_oe});
    check_val("databus_oe_n after reset", 32'd1, {31'b0, snes_databus_oe_n});
    for (k = 0; k < 12; k++) begin
      draw_bits(24, r);
      addr_list[k] = r[23:0];
      draw_bits(8, r);
      mcu_write(addr_list[k], r[7:0]);
      ref_mem[addr_list[k][16:0]] = r[7:0];
    end
    for (k = 0; k < 12; k++) begin
      mcu_read(addr_list[k], got);
      check_val("read data", {24'b0, ref_mem[addr_list[k][16:0]]}, {24'b0, got});
    end
    end_test();
  endtask

  task automatic rom_window_read();
    logic [31:0] r;
    logic [7:0]  bank;
    logic [14:0] off;
    logic [23:0] target;
    logic [7:0]  d;
    logic [7:0]  got;
    logic        oe_n;
    logic        dir;
    int          k;
    begin_test("rom_read");
    rom_mask = 24'h00_FFFF;
    cfg_write(2'd0, rom_mask);
    for (k = 0; k < 8; k++) begin
      draw_bits(8, r);
      bank = r[7:0] & 8'hBF;   // Keeps clear of the save RAM banks
      draw_bits(15, r);
      off = r[14:0];
      target = {2'b00, bank[6:0], off} & rom_mask;
      draw_bits(8, r);
      d = r[7:0];
      mcu_write(target, d);
      ref_mem[target[16:0]] = d;
      console_access({bank, 1'b1, off}, 1'b0, 8'h00, got, oe_n, dir);
      check_val("rom byte", {24'b0, d}, {24'b0, got});
    end
    end_test();
  endtask

  task automatic console_write_targets();
    logic [31:0] r;
    logic [3:0]  nib;
    logic [7:0]  bank;
    logic [14:0] off;
    logic [23:0] target;
    logic [7:0]  d;
    logic [7:0]  got;
    logic        oe_n;
    logic        dir;
    int          k;
    begin_test("saveram_write");
    sram_mask = 24'h00_1FFF;
    cfg_write(2'd1, sram_mask);
    for (k = 0; k < 6; k++) begin
      draw_bits(4, r);
      nib = r[3:0];
      if (nib > 4'hD) nib = nib - 4'h8;   // Banks 70h to 7Dh only
      draw_bits(1, r);
      bank = {r[0], 3'b111, nib};
      draw_bits(15, r);
      off = r[14:0];
      target = `SAVERAM_BASE + ({5'b00000, nib, off} & sram_mask);
      draw_bits(8, r);
      d = r[7:0];
      console_access({bank, 1'b0, off}, 1'b1, d, got, oe_n, dir);
      ref_mem[target[16:0]] = d;
      mcu_read(target, got);
      check_val("saveram byte", {24'b0, d}, {24'b0, got});
    end
    // ROM is read only from the console side
    for (k = 0; k < 4; k++) begin
      draw_bits(8, r);
      bank = r[7:0] & 8'hBF;
      draw_bits(15, r);
      off = r[14:0];
      target = {2'b00, bank[6:0], off} & rom_mask;
      draw_bits(8, r);
      d = ref_mem[target[16:0]] ^ (r[7:0] | 8'h01);
      console_access({bank, 1'b1, off}, 1'b1, d, got, oe_n, dir);
      mcu_read(target, got);
      check_val("rom unchanged", {24'b0, ref_mem[target[16:0]]}, {24'b0, got});
    end
    end_test();
  endtask

  task automatic command_window();
    logic [31:0] r;
    logic [7:0]  ref_cmd [16];
    logic [3:0]  idx;
    logic [7:0]  bank;
    logic [7:0]  got;
    logic        oe_n;
    logic        dir;
    int          k;
    begin_test("cmd_regs");
    for (k = 0; k < 16; k++) ref_cmd[k] = 8'h00;   // Reset value
    for (k = 0; k < 10; k++) begin
      draw_bits(4, r);
      idx = r[3:0];
      draw_bits(8, r);
      bank = r[7:0] & 8'hBF;
      draw_bits(8, r);
      console_access({bank, (`SNESCMD_BASE | {12'b0, idx})}, 1'b1, r[7:0], got, oe_n, dir);
      ref_cmd[idx] = r[7:0];
    end
    for (k = 0; k < 16; k++) begin
      draw_bits(8, r);
      bank = r[7:0] & 8'hBF;
      console_access({bank, (`SNESCMD_BASE | {12'b0, k[3:0]})}, 1'b0, 8'h00, got, oe_n, dir);
      check_val("cmd reg", {24'b0, ref_cmd[k]}, {24'b0, got});
      check_val("databus_oe_n", 32'd0, {31'b0, oe_n});
      check_val("databus_dir", 32'd1, {31'b0, dir});
    end
    end_test();
  endtask

  task automatic dead_console_read();
    logic [31:0] r;
    logic [23:0] a;
    begin_test("dead_read");
    draw_bits(24, r);
    a = r[23:0];
    draw_bits(8, r);
    mcu_write(a, r[7:0]);
    ref_mem[a[16:0]] = r[7:0];
    @(negedge snes_cpu_clk);
    cpu_run = 1'b0;   // CPU clock stays low from here
    repeat (40) @(negedge clk2);
    mcu_request(1'b0, a, 8'h00);
    repeat (1000) @(negedge clk2);
    check_val("mcu_rdy before dead", 32'd0, {31'b0, mcu_rdy});
    wait_mcu_ready(int'(`SNES_DEAD_TIMEOUT) + 2000);
    check_val("read data", {24'b0, ref_mem[a[16:0]]}, {24'b0, mcu_rdata});
    end_test();
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog

  initial begin
    int i;
    logic [15:0] w;
    for (i = 0; i < 131072; i++) begin
      w = fill_word(i[16:1]);
      ref_mem[i] = i[0] ? w[7:0] : w[15:8];   // Odd byte on the low lane
    end
    rst_n        = 1'b0;
    snes_addr    = 24'h000000;
    snes_rd_n    = 1'b1;
    snes_wr_n    = 1'b1;
    snes_data_in = 8'h00;
    mcu_addr     = 24'h000000;
    mcu_wdata    = 8'h00;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    cfg_we       = 1'b0;
    cfg_sel      = 2'd0;
    cfg_data     = 24'h000000;
    rom_mask     = 24'hFFFFFF;
    sram_mask    = 24'hFFFFFF;
    repeat (2) @(negedge clk2);
    rst_n   = 1'b1;
    cpu_run = 1'b1;
    mcu_roundtrip();
    rom_window_read();
    console_write_targets();
    command_window();
    dead_console_read();
    $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk2);
    $display("Error: watchdog expired after %0d cycles, a test did not finish", WATCHDOG);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* design/cart_top.sv */
`include "cart_consts.svh"

module cart_top (
  input  logic                    clk2,
  input  logic                    rst_n,
  // Console bus
  input  logic [`SNES_ADDR_W-1:0] snes_addr,
  input  logic                    snes_rd_n,
  input  logic                    snes_wr_n,
  input  logic                    snes_cpu_clk,
  input  logic [7:0]              snes_data_in,
  output logic [7:0]              snes_data_out,
  output logic                    snes_databus_oe_n,
  output logic                    snes_databus_dir,
  // PSRAM
  output logic [`ROM_ADDR_W-1:0]  rom_addr,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n,
  input  logic [15:0]             rom_data_in,
  output logic [15:0]             rom_data_out,
  output logic                    rom_data_oe,
  // MCU
  input  logic [`SNES_ADDR_W-1:0] mcu_addr,
  input  logic [7:0]              mcu_wdata,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  output logic                    mcu_rdy,
  output logic [7:0]              mcu_rdata,
  input  logic                    cfg_we,
  input  logic [1:0]              cfg_sel,
  input  logic [`SNES_ADDR_W-1:0] cfg_data
);

  snes_bus_pkg::snes_in_t  snes_in;
  snes_bus_pkg::snes_evt_t evt;
  snes_bus_pkg::map_t      map;
  mem_pkg::map_cfg_t       cfg;
  mem_pkg::mcu_req_t       mcu_req;
  mem_pkg::psram_out_t     psram;
  logic [`SNES_ADDR_W-1:0] addr_q;
  logic [7:0]              snes_rdata;
  logic [7:0]              rom_wdata;

  assign snes_in.addr    = snes_addr;
  assign snes_in.rd_n    = snes_rd_n;
  assign snes_in.wr_n    = snes_wr_n;
  assign snes_in.cpu_clk = snes_cpu_clk;

  assign mcu_req.addr  = mcu_addr;
  assign mcu_req.wdata = mcu_wdata;

  ////////////////////////////////////////////////////////////
  // Blocks

  snes_sync i_snes_sync (
    .clk2   (clk2),
    .rst_n  (rst_n),
    .snes   (snes_in),
    .addr_q (addr_q),
    .evt    (evt)
  );

  map_cfg_regs i_map_cfg_regs (
    .clk2     (clk2),
    .rst_n    (rst_n),
    .cfg_we   (cfg_we),
    .cfg_sel  (cfg_sel),
    .cfg_data (cfg_data),
    .cfg      (cfg)
  );

  lorom_mapper i_lorom_mapper (
    .addr (addr_q),
    .cfg  (cfg),
    .map  (map)
  );

  psram_arbiter i_psram_arbiter (
    .clk2         (clk2),
    .rst_n        (rst_n),
    .evt          (evt),
    .map          (map),
    .snes_wr_n    (snes_wr_n),
    .snes_data_in (snes_data_in),
    .rom_data_in  (rom_data_in),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_req      (mcu_req),
    .psram        (psram),
    .rom_wdata    (rom_wdata),
    .snes_rdata   (snes_rdata),
    .mcu_rdy      (mcu_rdy),
    .mcu_rdata    (mcu_rdata)
  );

  snes_bus_ctl i_snes_bus_ctl (
    .clk2              (clk2),
    .rst_n             (rst_n),
    .evt               (evt),
    .map               (map),
    .addr_q            (addr_q),
    .snes_data_in      (snes_data_in),
    .snes_rdata        (snes_rdata),
    .snes_data_out     (snes_data_out),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir)
  );

  // PSRAM pins, lane strobes pick the byte
  assign rom_addr     = psram.addr;
  assign rom_we_n     = psram.we_n;
  assign rom_bhe_n    = psram.bhe_n;
  assign rom_ble_n    = psram.ble_n;
  assign rom_data_oe  = psram.dout_en;
  assign rom_data_out = {rom_wdata, rom_wdata};

endmodule

/* design/snes_bus_ctl.sv */
`include "cart_consts.svh"

module snes_bus_ctl (
  input  logic                    clk2,
  input  logic                    rst_n,
  input  snes_bus_pkg::snes_evt_t evt,
  input  snes_bus_pkg::map_t      map,
  input  logic [`SNES_ADDR_W-1:0] addr_q,
  input  logic [7:0]              snes_data_in,
  input  logic [7:0]              snes_rdata,
  output logic [7:0]              snes_data_out,
  output logic                    snes_databus_oe_n,
  output logic                    snes_databus_dir
);

  logic [7:0] cmd_regs [16];
  logic [3:0] cmd_idx;
  logic       drive_en;

  assign cmd_idx = addr_q[3:0];

  // Command registers, written when the strobe goes away
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      cmd_regs <= '{default: '0};
    end else if (evt.wr_end && map.snescmd_en) begin
      cmd_regs[cmd_idx] <= snes_data_in;
    end
  end

  // Register window takes priority over memory data
  assign snes_data_out = map.snescmd_en ? cmd_regs[cmd_idx] : snes_rdata;

  // Buffer only for regions this cart answers
  assign drive_en = map.snescmd_en | map.is_rom | map.is_saveram;

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      snes_databus_oe_n <= 1'b1;
      snes_databus_dir  <= 1'b0;
    end else begin
      snes_databus_oe_n <= ~drive_en;
      snes_databus_dir  <= ~evt.rd_n_q;   // 1 = toward console
    end
  end

endmodule

/* arbiter/psram_arbiter.sv */
`include "cart_consts.svh"

module psram_arbiter (
  input  logic                    clk2,
  input  logic                    rst_n,
  input  snes_bus_pkg::snes_evt_t evt,
  input  snes_bus_pkg::map_t      map,
  input  logic                    snes_wr_n,
  input  logic [7:0]              snes_data_in,
  input  logic [15:0]             rom_data_in,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  mem_pkg::mcu_req_t       mcu_req,
  output mem_pkg::psram_out_t     psram,
  output logic [7:0]              rom_wdata,
  output logic [7:0]              snes_rdata,
  output logic                    mcu_rdy,
  output logic [7:0]              mcu_rdata
);

  typedef enum logic [14:0] {
    ST_IDLE          = 15'h0001,
    ST_SNES_RD_ADDR  = 15'h0002,
    ST_SNES_RD_WAIT  = 15'h0004,
    ST_SNES_RD_END   = 15'h0008,
    ST_SNES_WR_ADDR  = 15'h0010,
    ST_SNES_WR_WAIT1 = 15'h0020,
    ST_SNES_WR_DATA  = 15'h0040,
    ST_SNES_WR_WAIT2 = 15'h0080,
    ST_SNES_WR_END   = 15'h0100,
    ST_MCU_RD_ADDR   = 15'h0200,
    ST_MCU_RD_WAIT   = 15'h0400,
    ST_MCU_RD_END    = 15'h0800,
    ST_MCU_WR_ADDR   = 15'h1000,
    ST_MCU_WR_WAIT   = 15'h2000,
    ST_MCU_WR_END    = 15'h4000
  } state_t;

  state_t                  state;
  logic [`DELAY_W-1:0]     delay;
  logic                    done;
  logic                    rd_pend;
  logic                    wr_pend;
  logic [`SNES_ADDR_W-1:0] mcu_addr_q;
  logic [7:0]              mcu_wdata_q;
  logic                    we_n;
  logic                    dout_en;
  logic                    rom_sa;     // Address source, 1 = console
  logic                    dead_q;
  logic                    mcu_slot;
  logic                    lane_on;
  logic [`SNES_ADDR_W-1:0] sel_addr;
  logic [7:0]              lane_byte;

  ////////////////////////////////////////////////////////////
  // Address and byte lane

  assign sel_addr = rom_sa ? map.addr : mcu_addr_q;
  assign lane_byte = sel_addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];

  // Byte strobes only while an access runs
  assign lane_on = (state != ST_IDLE);

  assign psram.addr    = sel_addr[`SNES_ADDR_W-1:1];
  assign psram.bhe_n   = ~lane_on | sel_addr[0];
  assign psram.ble_n   = ~lane_on | ~sel_addr[0];   // Odd byte on the low lane
  assign psram.we_n    = we_n;
  assign psram.dout_en = dout_en;

  assign done = (delay == '0);

  // MCU may start when the console is idle for a while
  assign mcu_slot = evt.dead || evt.cycle_end;

  ////////////////////////////////////////////////////////////
  // MCU request capture

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (state == ST_MCU_RD_END || state == ST_MCU_WR_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge clk2) begin
    if (mcu_rrq || mcu_wrq) begin
      mcu_addr_q  <= mcu_req.addr;
      mcu_wdata_q <= mcu_req.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencer

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      we_n    <= 1'b1;
      dout_en <= 1'b0;
      rom_sa  <= 1'b1;
      dead_q  <= 1'b0;
    end else begin
      dead_q <= evt.dead;
      if (dead_q && !evt.dead) begin
        // Console woke up, abort and redo the MCU access later
        state   <= ST_IDLE;
        we_n    <= 1'b1;
        dout_en <= 1'b0;
      end else begin
        case (state)
          ST_IDLE: begin
            rom_sa  <= 1'b1;
            dout_en <= 1'b0;
            if (evt.cycle_start && !snes_wr_n) begin
              state <= ST_SNES_WR_ADDR;
              we_n  <= ~map.is_writable;   // ROM stays untouched
            end else if (evt.cycle_start) begin
              state <= ST_SNES_RD_ADDR;
            end else if (mcu_slot && rd_pend) begin
              state <= ST_MCU_RD_ADDR;
            end else if (mcu_slot && wr_pend) begin
              state <= ST_MCU_WR_ADDR;
            end
          end
          ST_SNES_RD_ADDR: state <= ST_SNES_RD_WAIT;
          ST_SNES_RD_WAIT: if (done) state <= ST_SNES_RD_END;
          ST_SNES_WR_ADDR: begin
            dout_en <= 1'b1;
            state   <= ST_SNES_WR_WAIT1;
          end
          ST_SNES_WR_WAIT1: if (done) state <= ST_SNES_WR_DATA;
          ST_SNES_WR_DATA:  state <= ST_SNES_WR_WAIT2;
          ST_SNES_WR_WAIT2: begin
            if (done) begin
              we_n    <= 1'b1;
              dout_en <= 1'b0;
              state   <= ST_SNES_WR_END;
            end
          end
          ST_SNES_RD_END, ST_SNES_WR_END: begin
            if (rd_pend) state <= ST_MCU_RD_ADDR;
            else if (wr_pend) state <= ST_MCU_WR_ADDR;
            else state <= ST_IDLE;
          end
          ST_MCU_RD_ADDR: begin
            rom_sa <= 1'b0;
            state  <= ST_MCU_RD_WAIT;
          end
          ST_MCU_RD_WAIT: if (done) state <= ST_MCU_RD_END;
          ST_MCU_RD_END:  state <= ST_IDLE;
          ST_MCU_WR_ADDR: begin
            rom_sa <= 1'b0;
            we_n   <= 1'b0;
            state  <= ST_MCU_WR_WAIT;
          end
          ST_MCU_WR_WAIT: begin
            dout_en <= 1'b1;
            if (done) begin
              we_n  <= 1'b1;
              state <= ST_MCU_WR_END;
            end
          end
          ST_MCU_WR_END: begin
            dout_en <= 1'b0;
            state   <= ST_IDLE;
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // Wait counter and data latches
  always_ff @(posedge clk2) begin
    case (state)
      ST_SNES_RD_ADDR: delay <= `ROM_RD_WAIT;
      ST_SNES_WR_ADDR: delay <= `ROM_WR_WAIT1;
      ST_SNES_WR_DATA: begin
        delay     <= `ROM_WR_WAIT2;
        rom_wdata <= snes_data_in;   // Console data has settled
      end
      ST_MCU_RD_ADDR: delay <= `ROM_RD_WAIT_MCU;
      ST_MCU_WR_ADDR: begin
        delay     <= `ROM_WR_WAIT_MCU;
        rom_wdata <= mcu_wdata_q;
      end
      ST_SNES_RD_WAIT: begin
        delay <= delay - 1'b1;
        if (done) snes_rdata <= lane_byte;
      end
      ST_SNES_WR_WAIT1, ST_SNES_WR_WAIT2, ST_MCU_RD_WAIT, ST_MCU_WR_WAIT: begin
        delay <= delay - 1'b1;
      end
      ST_MCU_RD_END: mcu_rdata <= lane_byte;
      default: ;
    endcase
  end

endmodule

/* mapper/lorom_mapper.sv */
`include "cart_consts.svh"

module lorom_mapper (
  input  logic [`SNES_ADDR_W-1:0] addr,
  input  mem_pkg::map_cfg_t       cfg,
  output snes_bus_pkg::map_t      map
);

  logic [6:0]              bank7;     // Bank without the fast-ROM bit
  logic [15:0]             offset;
  logic                    sram_bank;
  logic                    cmd_hit;
  logic [`SNES_ADDR_W-1:0] rom_addr;
  logic [`SNES_ADDR_W-1:0] sram_addr;

  assign bank7  = addr[22:16];
  assign offset = addr[15:0];

  // Banks 70h-7Dh and their upper mirror
  assign sram_bank = (bank7 >= 7'h70) && (bank7 <= 7'h7D);

  // 32K pages, one per bank, upper half of each bank
  assign rom_addr  = {2'b00, bank7, offset[14:0]} & cfg.rom_mask;
  assign sram_addr = `SAVERAM_BASE + ({5'b00000, bank7[3:0], offset[14:0]} & cfg.saveram_mask);

  // Command window only in the system banks
  assign cmd_hit = !bank7[6]
                && (offset >= `SNESCMD_BASE)
                && (offset <= `SNESCMD_BASE + 16'd15);

  assign map.is_rom      = offset[15] && !sram_bank;
  assign map.is_saveram  = sram_bank && !offset[15];
  assign map.is_writable = map.is_saveram;
  assign map.snescmd_en  = cmd_hit;
  assign map.addr        = map.is_saveram ? sram_addr : rom_addr;

endmodule

/* mapper/map_cfg_regs.sv */
`include "cart_consts.svh"

module map_cfg_regs (
  input  logic                    clk2,
  input  logic                    rst_n,
  input  logic                    cfg_we,
  input  logic [1:0]              cfg_sel,
  input  logic [`SNES_ADDR_W-1:0] cfg_data,
  output mem_pkg::map_cfg_t       cfg
);

  // Open masks until the MCU loads a game
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      cfg.rom_mask     <= '1;
      cfg.saveram_mask <= '1;
    end else if (cfg_we) begin
      case (cfg_sel)
        2'd0:    cfg.rom_mask     <= cfg_data;
        2'd1:    cfg.saveram_mask <= cfg_data;
        default: ;   // Spare selects
      endcase
    end
  end

endmodule

/* design/snes_sync.sv */
`include "cart_consts.svh"

module snes_sync (
  input  logic                    clk2,
  input  logic                    rst_n,
  input  snes_bus_pkg::snes_in_t  snes,
  output logic [`SNES_ADDR_W-1:0] addr_q,
  output snes_bus_pkg::snes_evt_t evt
);

  logic [`SNES_ADDR_W-1:0] addr_r [3];
  logic [7:0]              clk_r;
  logic [7:0]              wr_r;
  logic                    rd_r;
  logic [5:0]              clk_pair;
  logic [`DEAD_CNT_W-1:0]  dead_cnt;
  logic                    dead;

  // Address pipe, last two stages must agree
  always_ff @(posedge clk2) begin
    addr_r[0] <= snes.addr;
    addr_r[1] <= addr_r[0];
    addr_r[2] <= addr_r[1];
  end

  assign addr_q = addr_r[2] & addr_r[1];

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      clk_r <= '0;
      wr_r  <= '1;
      rd_r  <= 1'b1;
    end else begin
      clk_r <= {clk_r[6:0], snes.cpu_clk};
      wr_r  <= {wr_r[6:0], snes.wr_n};
      rd_r  <= snes.rd_n;
    end
  end

  // CPU clock counts as high only when two samples agree
  assign clk_pair = clk_r[7:2] & clk_r[6:1];

  // Dead timer, stops counting once tripped
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      dead_cnt <= '0;
      dead     <= 1'b0;
    end else begin
      if (clk_r[0]) dead_cnt <= '0;
      else if (!dead) dead_cnt <= dead_cnt + 1'b1;
      if (dead_cnt > `SNES_DEAD_TIMEOUT) dead <= 1'b1;
      else if (clk_r[0]) dead <= 1'b0;   // Console is back
    end
  end

  assign evt.cycle_start = (clk_pair == 6'b000001);
  assign evt.cycle_end   = (clk_pair == 6'b111110);
  assign evt.wr_end      = (wr_r[7:1] == 7'b0000001);
  assign evt.rd_n_q      = rd_r;
  assign evt.dead        = dead;

endmodule

/* common/mem_pkg.sv */
`include "cart_consts.svh"

package mem_pkg;

  // PSRAM control, write byte travels on its own
  typedef struct packed {
    logic [`ROM_ADDR_W-1:0] addr;
    logic                   we_n;
    logic                   bhe_n;
    logic                   ble_n;
    logic                   dout_en;
  } psram_out_t;

  // MCU access request, sampled with the rrq/wrq pulse
  typedef struct packed {
    logic [`SNES_ADDR_W-1:0] addr;
    logic [7:0]              wdata;
  } mcu_req_t;

  // Address masks, written by the MCU
  typedef struct packed {
    logic [`SNES_ADDR_W-1:0] rom_mask;
    logic [`SNES_ADDR_W-1:0] saveram_mask;
  } map_cfg_t;

endpackage

/* common/snes_bus_pkg.sv */
`include "cart_consts.svh"

package snes_bus_pkg;

  // Console pins as sampled at the cartridge edge
  typedef struct packed {
    logic [`SNES_ADDR_W-1:0] addr;
    logic                    rd_n;
    logic                    wr_n;
    logic                    cpu_clk;
  } snes_in_t;

  // One-cycle events from the synchronizer, plus two levels
  typedef struct packed {
    logic cycle_start;  // CPU clock rose
    logic cycle_end;    // CPU clock fell
    logic wr_end;       // Write strobe released
    logic rd_n_q;       // Registered read strobe
    logic dead;         // CPU clock stopped
  } snes_evt_t;

  // Mapper result for the current console address
  typedef struct packed {
    logic [`SNES_ADDR_W-1:0] addr;
    logic                    is_rom;
    logic                    is_saveram;
    logic                    is_writable;
    logic                    snescmd_en;
  } map_t;

endpackage

/* common/cart_consts.svh */
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// Bus widths
`define SNES_ADDR_W       24
`define ROM_ADDR_W        23   // PSRAM word address

// PSRAM delay counter width and wait counts, in CLK2 cycles
`define DELAY_W           4
`define ROM_RD_WAIT       4'd0
`define ROM_WR_WAIT1      4'd3   // Before console data is captured
`define ROM_WR_WAIT2      4'd1   // After capture, WE still low
`define ROM_RD_WAIT_MCU   4'd6
`define ROM_WR_WAIT_MCU   4'd5

// Console clock watchdog, about 1 ms of CLK2
`define DEAD_CNT_W        18
`define SNES_DEAD_TIMEOUT 18'd88000

// Memory map anchors
`define SAVERAM_BASE      24'hE00000
`define SNESCMD_BASE      16'h2A00   // 16 command registers from here

`endif
